//--- common/tcp_pkg.sv
package tcp_pkg;

    // endpoint addresses
    localparam logic [47:0] LOCAL_MAC  = 48'h06_00_AA_BB_CC_DD;
    localparam logic [47:0] REMOTE_MAC = 48'h06_00_AA_BB_CC_DE;
    localparam logic [31:0] LOCAL_IP   = {8'd192, 8'd168, 8'd2, 8'd240};
    localparam logic [31:0] REMOTE_IP  = {8'd192, 8'd168, 8'd2, 8'd241};

    localparam logic [15:0] LOCAL_PORT  = 16'd12345;
    localparam logic [15:0] REMOTE_PORT = 16'd23456;

    // ethernet and ipv4 header words
    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [15:0] IP_VER_IHL_TOS = 16'h4500;
    localparam logic [15:0] IP_TOTAL_LEN   = 16'd40;
    localparam logic [15:0] IP_FRAG_DF     = 16'h4000;
    localparam logic [15:0] IP_TTL_PROTO   = 16'h4006;
    localparam logic [15:0] IP_PROTO_TCP   = 16'h0006;

    // tcp header words, no options and no payload
    localparam logic [3:0]  TCP_DATA_OFFSET = 4'd5;
    localparam logic [15:0] TCP_WINDOW      = 16'd512;
    localparam logic [15:0] TCP_LEN         = 16'd20;

    localparam logic [31:0] RECON_CYCLES = 32'd256;

    // network beat format
    localparam int NET_W       = 64;
    localparam int BEAT_CNT_W  = 3;
    localparam int FRAME_BEATS = 7;

    localparam logic [BEAT_CNT_W-1:0] FULL_BEAT_CNT = 3'd7;
    localparam logic [BEAT_CNT_W-1:0] LAST_BEAT_CNT = 3'd5;

    // wide enough for twelve 16-bit words before folding
    localparam int CSUM_W = 20;

    // fixed part of the ipv4 header sum
    localparam logic [CSUM_W-1:0] IP_CSUM_BASE = IP_VER_IHL_TOS + IP_TOTAL_LEN + IP_FRAG_DF
        + IP_TTL_PROTO + LOCAL_IP[31:16] + LOCAL_IP[15:0] + REMOTE_IP[31:16] + REMOTE_IP[15:0];

    // fixed part of the tcp sum including the pseudo-header, ack is always zero
    localparam logic [CSUM_W-1:0] TCP_CSUM_BASE = LOCAL_PORT + REMOTE_PORT + LOCAL_IP[31:16]
        + LOCAL_IP[15:0] + REMOTE_IP[31:16] + REMOTE_IP[15:0] + IP_PROTO_TCP + TCP_LEN
        + TCP_WINDOW;

    // reserved bits and flags of the data-offset word
    typedef enum logic [11:0] {
        TCP_FLAG_SYN = 12'h002,
        TCP_FLAG_RST = 12'h004
    } tcp_flag_e;

    typedef enum logic {
        CONN_RST,
        CONN_SYN
    } conn_state_e;

    typedef enum logic [2:0] {
        BEAT_MAC0     = 3'd0,
        BEAT_MAC1_IP  = 3'd1,
        BEAT_IP_ID    = 3'd2,
        BEAT_IP_ADDR  = 3'd3,
        BEAT_TCP_PORT = 3'd4,
        BEAT_TCP_SEQ  = 3'd5,
        BEAT_TCP_TAIL = 3'(FRAME_BEATS - 1)
    } beat_e;

    typedef logic [NET_W-1:0] tcp_net_data_t;

endpackage

//--- rtl/tcp_conn_control.sv
module tcp_conn_control (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               phy_ready,
    input  logic               established,
    input  logic               frame_ack,
    output logic               frame_req,
    output tcp_pkg::tcp_flag_e frame_flags
);
    import tcp_pkg::*;

    logic [31:0] recon_timer;
    conn_state_e state;
    logic        link_idle;
    logic        rst_accepted;
    logic        start_rst;

    // link up but nobody on the other end yet
    assign link_idle = phy_ready && !established;

    // state is CONN_SYN only while the RST request is outstanding
    assign rst_accepted = frame_ack && (state == CONN_SYN);

    assign start_rst = !frame_req && link_idle && (recon_timer == '0);

    // reconnect countdown, held at full value while connected
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            recon_timer <= '0;
        end else if (established || rst_accepted) begin
            recon_timer <= RECON_CYCLES;
        end else if (recon_timer != '0) begin
            recon_timer <= recon_timer - 32'd1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_req   <= 1'b0;
            frame_flags <= TCP_FLAG_RST;
            state       <= CONN_RST;
        end else if (frame_ack) begin
            state <= CONN_RST;
            if (rst_accepted && link_idle) begin
                // SYN goes out right behind the RST
                frame_flags <= TCP_FLAG_SYN;
            end else begin
                frame_req <= 1'b0;
            end
        end else if (start_rst) begin
            frame_req   <= 1'b1;
            frame_flags <= TCP_FLAG_RST;
            state       <= CONN_SYN;
        end
    end

endmodule

//--- tcp_tx/tcp_header_checksum.sv
module tcp_header_checksum (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               csum_start,
    input  logic [15:0]        ip_id,
    input  tcp_pkg::tcp_flag_e flags,
    input  logic [31:0]        seq,
    output logic [15:0]        ip_csum,
    output logic [15:0]        tcp_csum
);
    import tcp_pkg::*;

    logic [CSUM_W-1:0] ip_sum;
    logic [CSUM_W-1:0] tcp_sum;
    logic              sum_vld;

    // end-around carry, then one's complement
    function automatic logic [15:0] fold_invert(input logic [CSUM_W-1:0] sum);
        logic [16:0] partial;
        logic [15:0] folded;
        partial = sum[15:0] + sum[CSUM_W-1:16];
        folded  = partial[15:0] + 16'(partial[16]);
        return ~folded;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum_vld <= 1'b0;
        end else begin
            sum_vld <= csum_start;
        end
    end

    // stage one, raw sums of the per-frame words on top of the fixed part
    always_ff @(posedge clk) begin
        if (csum_start) begin
            ip_sum  <= IP_CSUM_BASE + ip_id;
            tcp_sum <= TCP_CSUM_BASE + seq[31:16] + seq[15:0] + {TCP_DATA_OFFSET, flags};
        end
    end

    // stage two, results held until the next frame
    always_ff @(posedge clk) begin
        if (sum_vld) begin
            ip_csum  <= fold_invert(ip_sum);
            tcp_csum <= fold_invert(tcp_sum);
        end
    end

endmodule

//--- tcp_tx/tcp_frame_emitter.sv
module tcp_frame_emitter (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            frame_req,
    input  tcp_pkg::tcp_flag_e              frame_flags,
    output logic                            frame_ack,
    output logic                            csum_start,
    output logic [15:0]                     ip_id,
    output logic [31:0]                     seq,
    input  logic [15:0]                     ip_csum,
    input  logic [15:0]                     tcp_csum,
    input  logic                            net_ready,
    output tcp_pkg::tcp_net_data_t          net_data,
    output logic                            net_valid,
    output logic [tcp_pkg::BEAT_CNT_W-1:0]  net_cnt,
    output logic                            net_fin
);
    import tcp_pkg::*;

    beat_e         beat;
    beat_e         load_beat;
    tcp_flag_e     flags_q;
    tcp_net_data_t beat_data;
    logic [15:0]   ip_id_q;
    logic [31:0]   seq_q;
    logic          tail_out;
    logic          tail_done;
    logic          load;

    assign tail_out  = net_valid && (beat == BEAT_TCP_TAIL);
    assign tail_done = tail_out && net_ready;

    // a new frame starts only into an empty register or behind a leaving tail
    assign frame_ack  = frame_req && (!net_valid || tail_done);
    assign csum_start = frame_ack;

    assign load = frame_ack || (net_valid && net_ready && !tail_out);

    // values of the frame being accepted, counters step as the tail leaves
    assign ip_id = ip_id_q + 16'(tail_done);
    assign seq   = seq_q + 32'(tail_done && (flags_q == TCP_FLAG_SYN));

    always_comb begin
        load_beat = frame_ack ? BEAT_MAC0 : beat_e'(beat + 3'd1);
        case (load_beat)
            BEAT_MAC0: begin
                beat_data = {LOCAL_MAC, REMOTE_MAC[47:32]};
            end
            BEAT_MAC1_IP: begin
                beat_data = {REMOTE_MAC[31:0], ETHERTYPE_IPV4, IP_VER_IHL_TOS};
            end
            BEAT_IP_ID: begin
                beat_data = {IP_TOTAL_LEN, ip_id_q, IP_FRAG_DF, IP_TTL_PROTO};
            end
            BEAT_IP_ADDR: begin
                // ip_csum settled two cycles after accept
                beat_data = {ip_csum, LOCAL_IP, REMOTE_IP[31:16]};
            end
            BEAT_TCP_PORT: begin
                beat_data = {REMOTE_IP[15:0], LOCAL_PORT, REMOTE_PORT, seq_q[31:16]};
            end
            BEAT_TCP_SEQ: begin
                // ack number stays zero
                beat_data = {seq_q[15:0], 32'h0, TCP_DATA_OFFSET, flags_q};
            end
            default: begin
                // window, checksum, urgent pointer, two pad bytes
                beat_data = {TCP_WINDOW, tcp_csum, 16'h0, 16'h0};
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat      <= BEAT_MAC0;
            net_valid <= 1'b0;
            net_fin   <= 1'b0;
            ip_id_q   <= '0;
            seq_q     <= '0;
        end else begin
            if (load) begin
                beat      <= load_beat;
                net_valid <= 1'b1;
                net_fin   <= (load_beat == BEAT_TCP_TAIL);
            end else if (tail_done) begin
                net_valid <= 1'b0;
                net_fin   <= 1'b0;
            end
            if (tail_done) begin
                ip_id_q <= ip_id;
                seq_q   <= seq;
            end
        end
    end

    // beat payload and per-frame flags
    always_ff @(posedge clk) begin
        if (load) begin
            net_data <= beat_data;
            net_cnt  <= (load_beat == BEAT_TCP_TAIL) ? LAST_BEAT_CNT : FULL_BEAT_CNT;
        end
        if (frame_ack) begin
            flags_q <= frame_flags;
        end
    end

endmodule

//--- rtl/tcp_tx_top.sv
module tcp_tx_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            phy_ready,
    input  logic                            established,
    input  logic                            net_ready,
    output tcp_pkg::tcp_net_data_t          net_data,
    output logic                            net_valid,
    output logic [tcp_pkg::BEAT_CNT_W-1:0]  net_cnt,
    output logic                            net_fin
);
    import tcp_pkg::*;

    logic        frame_req;
    tcp_flag_e   frame_flags;
    logic        frame_ack;
    logic        csum_start;
    logic [15:0] ip_id;
    logic [31:0] seq;
    logic [15:0] ip_csum;
    logic [15:0] tcp_csum;

    // picks RST or SYN and when to send it
    tcp_conn_control conn_control_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .phy_ready   (phy_ready),
        .established (established),
        .frame_ack   (frame_ack),
        .frame_req   (frame_req),
        .frame_flags (frame_flags)
    );

    // flags come straight from the controller, valid on the accept cycle
    tcp_header_checksum header_checksum_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .csum_start (csum_start),
        .ip_id      (ip_id),
        .flags      (frame_flags),
        .seq        (seq),
        .ip_csum    (ip_csum),
        .tcp_csum   (tcp_csum)
    );

    tcp_frame_emitter frame_emitter_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_req   (frame_req),
        .frame_flags (frame_flags),
        .frame_ack   (frame_ack),
        .csum_start  (csum_start),
        .ip_id       (ip_id),
        .seq         (seq),
        .ip_csum     (ip_csum),
        .tcp_csum    (tcp_csum),
        .net_ready   (net_ready),
        .net_data    (net_data),
        .net_valid   (net_valid),
        .net_cnt     (net_cnt),
        .net_fin     (net_fin)
    );

endmodule

//--- bench/tcp_tx_tb.sv
module tcp_tx_tb;
    import tcp_pkg::*;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  phy_ready;
    logic                  established;
    logic                  net_ready = 1'b0;
    tcp_net_data_t         net_data;
    logic                  net_valid;
    logic [BEAT_CNT_W-1:0] net_cnt;
    logic                  net_fin;

    // reference model stepping on every transferred beat
    logic [2:0]            model_beat;
    logic [31:0]           model_frames;
    logic [15:0]           model_id;
    logic [31:0]           model_seq;
    logic [11:0]           model_flags;
    tcp_net_data_t         exp_data;
    logic [BEAT_CNT_W-1:0] exp_cnt;

    // previous-cycle view of the outputs
    logic                  stall_q;
    tcp_net_data_t         data_q;
    logic [BEAT_CNT_W-1:0] cnt_q;
    logic                  fin_q;
    logic                  valid_q;
    logic                  rst_start;
    logic                  rst_seen;
    logic [31:0]           last_rst_cycle;
    logic [31:0]           cycle = '0;
    logic [31:0]           rng = 32'd34201;

    tcp_tx_top dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .phy_ready   (phy_ready),
        .established (established),
        .net_ready   (net_ready),
        .net_data    (net_data),
        .net_valid   (net_valid),
        .net_cnt     (net_cnt),
        .net_fin     (net_fin)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [15:0] fold_complement(input logic [31:0] acc);
        logic [31:0] sum;
        sum = acc;
        while (sum[31:16] != 16'h0) begin
            sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
        end
        return ~sum[15:0];
    endfunction

    function automatic logic [15:0] ip_checksum(input logic [15:0] id);
        return fold_complement(32'(IP_VER_IHL_TOS) + 32'(IP_TOTAL_LEN) + 32'(id)
            + 32'(IP_FRAG_DF) + 32'(IP_TTL_PROTO) + 32'(LOCAL_IP[31:16]) + 32'(LOCAL_IP[15:0])
            + 32'(REMOTE_IP[31:16]) + 32'(REMOTE_IP[15:0]));
    endfunction

    // pseudo-header plus tcp header with zero ack and urgent pointer
    function automatic logic [15:0] tcp_checksum(input logic [31:0] sq, input logic [11:0] fl);
        return fold_complement(32'(LOCAL_PORT) + 32'(REMOTE_PORT) + 32'(LOCAL_IP[31:16])
            + 32'(LOCAL_IP[15:0]) + 32'(REMOTE_IP[31:16]) + 32'(REMOTE_IP[15:0]) + 32'h6
            + 32'(TCP_LEN) + 32'(sq[31:16]) + 32'(sq[15:0]) + 32'({TCP_DATA_OFFSET, fl})
            + 32'(TCP_WINDOW));
    endfunction

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("RESULT: FAIL");
        $fatal(1, "testbench stopped on first error");
    endtask

    // strict alternation starting with RST
    assign model_flags = model_frames[0] ? 12'(TCP_FLAG_SYN) : 12'(TCP_FLAG_RST);
    assign exp_cnt     = (model_beat == 3'd6) ? 3'd5 : 3'd7;
    assign rst_start   = net_valid && !valid_q && (model_flags == 12'(TCP_FLAG_RST));

    always_comb begin
        case (model_beat)
            3'd0: exp_data = {LOCAL_MAC, REMOTE_MAC[47:32]};
            3'd1: exp_data = {REMOTE_MAC[31:0], ETHERTYPE_IPV4, IP_VER_IHL_TOS};
            3'd2: exp_data = {IP_TOTAL_LEN, model_id, IP_FRAG_DF, IP_TTL_PROTO};
            3'd3: exp_data = {ip_checksum(model_id), LOCAL_IP, REMOTE_IP[31:16]};
            3'd4: exp_data = {REMOTE_IP[15:0], LOCAL_PORT, REMOTE_PORT, model_seq[31:16]};
            3'd5: exp_data = {model_seq[15:0], 32'h0, TCP_DATA_OFFSET, model_flags};
            default: exp_data = {TCP_WINDOW, tcp_checksum(model_seq, model_flags), 32'h0};
        endcase
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            model_beat   <= 3'd0;
            model_frames <= '0;
            model_id     <= '0;
            model_seq    <= '0;
        end else if (net_valid && net_ready) begin
            if (model_beat == 3'd6) begin
                model_beat   <= 3'd0;
                model_frames <= model_frames + 32'd1;
                model_id     <= model_id + 16'd1;
                if (model_flags == 12'(TCP_FLAG_SYN)) begin
                    model_seq <= model_seq + 32'd1;
                end
            end else begin
                model_beat <= model_beat + 3'd1;
            end
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stall_q        <= 1'b0;
            valid_q        <= 1'b0;
            rst_seen       <= 1'b0;
            last_rst_cycle <= '0;
        end else begin
            stall_q <= net_valid && !net_ready;
            valid_q <= net_valid;
            if (rst_start) begin
                rst_seen       <= 1'b1;
                last_rst_cycle <= cycle;
            end
        end
    end

    always @(posedge clk) begin
        data_q <= net_data;
        cnt_q  <= net_cnt;
        fin_q  <= net_fin;
        // sink stalls about one cycle in four
        rng       <= xorshift32(rng);
        net_ready <= (rng[1:0] != 2'b00);
    end

    always @(posedge clk) begin
        cycle <= cycle + 32'd1;
        if (cycle >= 8 * (RECON_CYCLES + 32'd40) + 32'd200) begin
            stop_on_error("timeout, frames did not complete in time");
        end
    end

    link_down_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !phy_ready |-> !net_valid && !net_fin)
        else stop_on_error("net_valid or net_fin raised while the link is down");

    beat_data_ok: assert property (@(posedge clk) disable iff (!rst_n)
        net_valid |-> net_data == exp_data)
        else stop_on_error($sformatf("Mismatch net_data frame %0d beat %0d: got %h expected %h",
            model_frames, model_beat, net_data, exp_data));

    beat_cnt_ok: assert property (@(posedge clk) disable iff (!rst_n)
        net_valid |-> net_cnt == exp_cnt)
        else stop_on_error($sformatf("Mismatch net_cnt beat %0d: got %h expected %h",
            model_beat, net_cnt, exp_cnt));

    beat_fin_ok: assert property (@(posedge clk) disable iff (!rst_n)
        net_fin == (net_valid && model_beat == 3'd6))
        else stop_on_error($sformatf("Mismatch net_fin beat %0d: got %h expected %h",
            model_beat, net_fin, (net_valid && model_beat == 3'd6)));

    stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        stall_q |-> net_valid && net_data == data_q && net_cnt == cnt_q && net_fin == fin_q)
        else stop_on_error($sformatf(
            "Mismatch net outputs across stall: valid %h data %h/%h cnt %h/%h fin %h/%h",
            net_valid, data_q, net_data, cnt_q, net_cnt, fin_q, net_fin));

    rst_spacing: assert property (@(posedge clk) disable iff (!rst_n)
        rst_start && rst_seen |-> cycle - last_rst_cycle >= RECON_CYCLES)
        else stop_on_error("RST frames started closer together than the reconnect interval");

    connected_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        established |-> !net_valid)
        else stop_on_error("a frame started while the connection was established");

    initial begin
        rst_n       = 1'b0;
        phy_ready   = 1'b0;
        established = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        // link still down
        repeat (30) @(posedge clk);
        phy_ready <= 1'b1;
        while (model_frames < 32'd8) begin
            @(posedge clk);
        end
        // connected so no new frame may start
        established <= 1'b1;
        repeat (RECON_CYCLES + 32'd50) @(posedge clk);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- project.f
common/tcp_pkg.sv
rtl/tcp_conn_control.sv
tcp_tx/tcp_header_checksum.sv
tcp_tx/tcp_frame_emitter.sv
rtl/tcp_tx_top.sv
bench/tcp_tx_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tcp_tx_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
